//--- ternary_alu.f
+incdir+common
common/trit_pkg.sv
common/alu_pkg.sv
source/op_decoder.sv
source/trit_logic_unit.sv
adder/trit_full_adder.sv
adder/trit_add_sub.sv
source/result_stage.sv
source/ternary_alu.sv
test/alu_checker.sv
test/tb_ternary_alu.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_ternary_alu
FILELIST = ternary_alu.f
LOG      = sim.log
PASS_MSG = STATUS: PASS

.PHONY: sim clean

# Verdict comes from the log, not the exit code
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- test/tb_ternary_alu.sv
`default_nettype none

`include "ternary_alu_defs.svh"

module tb_ternary_alu;

    import trit_pkg::*;
    import alu_pkg::*;

    logic    clock;
    logic    arst_n;
    logic    alu_enable;
    opcode_t opcode;
    tword_u  input1;
    tword_u  input2;
    tword_u  alu_out;
    int      results_seen;          // Enabled edges already compared
    int      checks;                // All compares so far
    int      errors;
    integer  seed;
    int      tests_passed  = 0;
    int      tests_failed  = 0;
    int      errors_before = 0;
    logic    timed_out     = 1'b0;

    ternary_alu dut_i (.*);
    alu_checker checker_i (.*);

    initial begin
        clock = 1'b0;
        forever begin
            #20 clock = ~clock;
        end
    end

    // Legal trit codes only
    function automatic tword_u random_word();
        tword_u w;
        for (int i = 0; i < `WORD_TRITS; i++) begin
            case ($unsigned($random(seed)) % 3)
                0:       w.trits[i] = zero;
                1:       w.trits[i] = pos;
                default: w.trits[i] = neg;
            endcase
        end
        return w;
    endfunction

    function automatic tword_u fill_word(input trit_e t);
        tword_u w;
        for (int i = 0; i < `WORD_TRITS; i++) begin
            w.trits[i] = t;
        end
        return w;
    endfunction

    task automatic finish_run();
        $display("Tests %0d passed, %0d failed; checks %0d, errors %0d",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    // Bounded wait on a checker counter
    task automatic wait_count(input int target, input logic results_only);
        int cycles;
        cycles = 0;
        if (timed_out) begin
            return;                 // Nothing left to wait for
        end
        while ((results_only ? results_seen : checks) < target && cycles < 16) begin
            @(posedge clock);
            cycles++;
        end
        if ((results_only ? results_seen : checks) < target) begin
            $display("Timeout: the checker saw no new result within %0d cycles", cycles);
            timed_out = 1'b1;
        end
    endtask

    // One enabled cycle, then wait for its compare
    task automatic apply_op(input opcode_t op, input tword_u a, input tword_u b);
        int target;
        if (timed_out) begin
            return;
        end
        target = results_seen + 1;
        @(negedge clock);
        alu_enable = 1'b1;
        opcode     = op;
        input1     = a;
        input2     = b;
        @(negedge clock);
        alu_enable = 1'b0;
        wait_count(target, 1'b1);
    endtask

    task automatic run_random(input opcode_t op, input int count);
        for (int i = 0; i < count; i++) begin
            apply_op(op, random_word(), random_word());
        end
    endtask

    task automatic end_test(input string name);
        if (timed_out) begin
            tests_failed++;
            $display("test %-8s not completed after a timeout", name);
        end else if (errors == errors_before) begin
            tests_passed++;
            $display("test %-8s passed", name);
        end else begin
            tests_failed++;
            $display("test %-8s failed with %0d errors", name, errors - errors_before);
        end
        errors_before = errors;
    endtask

    initial begin
        tword_u w;
        tword_u one;
        int     target;
        seed        = 32'hd30a_0bbb;
        arst_n      = 1'b0;
        alu_enable  = 1'b0;
        opcode      = '0;
        input1.bits = '0;
        input2.bits = '0;
        one         = fill_word(zero);
        one.trits[0] = pos;
        for (int i = 0; i < 4; i++) begin
            @(posedge clock);
        end
        @(negedge clock);
        arst_n = 1'b1;
        wait_count(checks + 3, 1'b0);   // Idle cycles must read zero
        end_test("reset");

        run_random(op_not, 50);
        end_test("not");
        run_random(op_and, 50);
        end_test("and");
        run_random(op_or, 50);
        end_test("or");
        run_random(op_xor, 50);
        end_test("xor");

        apply_op(op_add, fill_word(pos), one);   // Top wraps to all -1
        run_random(op_add, 50);
        end_test("add");
        run_random(op_addi, 30);
        end_test("addi");
        w = random_word();
        apply_op(op_sub, w, w);
        apply_op(op_sub, fill_word(neg), one);   // Bottom wraps to all +1
        run_random(op_sub, 50);
        end_test("sub");

        for (int i = 0; i < 20; i++) begin
            w = random_word();
            apply_op(op_comp, w, w);
            apply_op(op_comp, w, random_word());
        end
        end_test("comp");

        // Code points outside +1..+9
        apply_op({zero, zero, zero}, random_word(), random_word());
        apply_op({neg, neg, neg}, random_word(), random_word());
        apply_op({neg, zero, pos}, random_word(), random_word());
        apply_op({zero, zero, neg}, random_word(), random_word());
        end_test("unknown");
        run_random(op_andi, 30);
        end_test("andi");

        // Inputs move while enable stays low
        apply_op(op_add, random_word(), random_word());
        target = checks + 10;
        for (int i = 0; i < 10; i++) begin
            @(negedge clock);
            opcode = op_sub;
            input1 = random_word();
            input2 = random_word();
        end
        wait_count(target, 1'b0);
        end_test("hold");

        finish_run();
    end

endmodule

`default_nettype wire

//--- test/alu_checker.sv
`default_nettype none

`include "ternary_alu_defs.svh"

// Reference model of the ALU register and comparison against the DUT
module alu_checker (
    input  logic             clock,
    input  logic             arst_n,
    input  logic             alu_enable,
    input  alu_pkg::opcode_t opcode,
    input  trit_pkg::tword_u input1,
    input  trit_pkg::tword_u input2,
    input  trit_pkg::tword_u alu_out,
    output int               results_seen,
    output int               checks,
    output int               errors
);

    import trit_pkg::*;
    import alu_pkg::*;

    localparam int span      = 3 ** `WORD_TRITS;   // 19683 distinct values
    localparam int max_value = (span - 1) / 2;     // 9841

    // Request captured on the last enabled edge
    typedef struct packed {
        opcode_t op;
        tword_u  a;
        tword_u  b;
    } request_s;

    request_s last_req;
    tword_u   model;                // Expected register contents
    logic     pending;              // Enabled edge waiting for its compare
    logic     armed;                // Out of reset at the last rising edge
    int       result_count = 0;
    int       check_count  = 0;
    int       error_count  = 0;

    function automatic int trit_value(input logic [1:0] code);
        case (code)
            2'b01:   return 1;
            2'b10:   return -1;
            default: return 0;      // Zero and the unused code
        endcase
    endfunction

    function automatic trit_e trit_code(input int t);
        return (t > 0) ? pos : (t < 0) ? neg : zero;
    endfunction

    function automatic int word_value(input tword_u w);
        int v;
        v = 0;
        for (int i = `WORD_TRITS - 1; i >= 0; i--) begin
            v = v * 3 + trit_value(w.trits[i]);   // Most significant trit first
        end
        return v;
    endfunction

    // Wrap into +-9841, then split into balanced digits
    function automatic tword_u value_word(input int v);
        tword_u w;
        int     d;
        v = v % span;
        if (v > max_value) begin
            v = v - span;
        end
        if (v < -max_value) begin
            v = v + span;
        end
        for (int i = 0; i < `WORD_TRITS; i++) begin
            d = v % 3;              // Sign follows v, so -2..2
            if (d > 1) begin
                d = d - 3;
            end
            if (d < -1) begin
                d = d + 3;
            end
            w.trits[i] = trit_code(d);
            v = (v - d) / 3;
        end
        return w;
    endfunction

    function automatic tword_u expected_result(input opcode_t op, input tword_u a,
                                               input tword_u b);
        tword_u r;
        int     x;
        int     y;
        int     t;
        r = a;                      // Unknown opcode passes input1
        case (op)
            op_add, op_addi: r = value_word(word_value(a) + word_value(b));
            op_sub:          r = value_word(word_value(a) - word_value(b));
            op_comp:         r = value_word((a.bits == b.bits) ? 1 : 0);
            op_not, op_and, op_andi, op_or, op_xor: begin
                for (int i = 0; i < `WORD_TRITS; i++) begin
                    x = trit_value(a.trits[i]);
                    y = trit_value(b.trits[i]);
                    case (op)
                        op_not:  t = -x;
                        op_or:   t = (x > y) ? x : y;
                        op_xor: begin
                            t = x + y;          // Arithmetic sum of the pair
                            // Both doubles give -1
                            if (t == 2 || t == -2) begin
                                t = -1;
                            end
                        end
                        default: t = (x < y) ? x : y;   // AND and ANDI take the minimum
                    endcase
                    r.trits[i] = trit_code(t);
                end
            end
            default: ;
        endcase
        return r;
    endfunction

    // Model follows the DUT register edge for edge
    always @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            model.bits <= '0;
            pending    <= 1'b0;
            armed      <= 1'b0;
        end else begin
            armed   <= 1'b1;
            pending <= alu_enable;
            if (alu_enable) begin
                model    <= expected_result(opcode, input1, input2);
                last_req <= '{opcode, input1, input2};
            end
        end
    end

    // alu_out is settled mid-cycle, so compare on the falling edge
    always @(negedge clock) begin
        if (armed) begin
            check_count <= check_count + 1;
            if (pending) begin
                result_count <= result_count + 1;
            end
            if (alu_out.bits !== model.bits) begin
                error_count <= error_count + 1;
                $display("[ERROR] %0t: alu_out %h, expected %h (opcode %h, input1 %h, input2 %h)",
                         $time, alu_out.bits, model.bits, last_req.op,
                         last_req.a.bits, last_req.b.bits);
            end
        end
    end

    assign results_seen = result_count;
    assign checks       = check_count;
    assign errors       = error_count;

endmodule

`default_nettype wire

//--- source/ternary_alu.sv
`default_nettype none

// Balanced-ternary ALU top, 9-trit words
// Result appears one cycle after an enabled edge
module ternary_alu (
    input  logic             clock,
    input  logic             arst_n,
    input  logic             alu_enable,
    input  alu_pkg::opcode_t opcode,
    input  trit_pkg::tword_u input1,
    input  trit_pkg::tword_u input2,
    output trit_pkg::tword_u alu_out
);

    import trit_pkg::*;
    import alu_pkg::*;

    alu_req_s req;
    tword_u   not_word;
    tword_u   and_word;
    tword_u   or_word;
    tword_u   xor_word;
    tword_u   eq_word;
    tword_u   sum_word;

    op_decoder decoder_i (
        .opcode (opcode),
        .req    (req)
    );

    trit_logic_unit logic_i (
        .a        (input1),
        .b        (input2),
        .not_word (not_word),
        .and_word (and_word),
        .or_word  (or_word),
        .xor_word (xor_word),
        .eq_word  (eq_word)
    );

    trit_add_sub adder_i (
        .a        (input1),
        .b        (input2),
        .subtract (req.subtract),
        .sum      (sum_word)
    );

    result_stage result_i (
        .clock    (clock),
        .arst_n   (arst_n),
        .enable   (alu_enable),
        .op       (req.op),
        .a        (input1),
        .not_word (not_word),
        .and_word (and_word),
        .or_word  (or_word),
        .xor_word (xor_word),
        .eq_word  (eq_word),
        .sum_word (sum_word),
        .alu_out  (alu_out)
    );

endmodule

`default_nettype wire

//--- source/result_stage.sv
`default_nettype none

// Result select and output register
module result_stage (
    input  logic             clock,
    input  logic             arst_n,
    input  logic             enable,
    input  alu_pkg::alu_op_e op,
    input  trit_pkg::tword_u a,
    input  trit_pkg::tword_u not_word,
    input  trit_pkg::tword_u and_word,
    input  trit_pkg::tword_u or_word,
    input  trit_pkg::tword_u xor_word,
    input  trit_pkg::tword_u eq_word,
    input  trit_pkg::tword_u sum_word,
    output trit_pkg::tword_u alu_out
);

    import trit_pkg::*;
    import alu_pkg::*;

    tword_u next_word;

    always_comb begin
        case (op)
            logic_not:            next_word = not_word;
            logic_and:            next_word = and_word;
            logic_or:             next_word = or_word;
            logic_xor:            next_word = xor_word;
            arith_add, arith_sub: next_word = sum_word;  // One adder for both
            cmp_eq:               next_word = eq_word;
            default:              next_word = a;         // pass_a
        endcase
    end

    // Loads only on enabled edges
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            alu_out.bits <= '0;
        end else if (enable) begin
            alu_out <= next_word;
        end
    end

    // Decoder fell back to pass-through for this request
    unknown_op_a: assert property (@(posedge clock) disable iff (!arst_n)
        enable |-> op != pass_a)
        else $warning("unknown opcode, input1 passed through");

    // Output holds across cycles without enable
    hold_a: assert property (@(posedge clock) disable iff (!arst_n)
        !$past(enable) |-> $stable(alu_out.bits));

endmodule

`default_nettype wire

//--- adder/trit_add_sub.sv
`default_nettype none

`include "ternary_alu_defs.svh"

// 9-trit ripple adder
// Subtraction negates each trit of b, no extra carry needed in ternary
module trit_add_sub (
    input  trit_pkg::tword_u a,
    input  trit_pkg::tword_u b,
    input  logic             subtract,
    output trit_pkg::tword_u sum
);

    import trit_pkg::*;

    // Maps the unused code to zero and optionally negates
    function automatic trit_e cond_trit(input trit_e t, input logic flip);
        case (t)
            pos:     return flip ? neg : pos;
            neg:     return flip ? pos : neg;
            default: return zero;
        endcase
    endfunction

    trit_e [`WORD_TRITS:0] carry;   // Top carry falls off, result wraps

    assign carry[0] = zero;

    for (genvar i = 0; i < `WORD_TRITS; i++) begin : g_stage
        trit_e a_t;
        trit_e b_t;

        assign a_t = cond_trit(a.trits[i], 1'b0);
        assign b_t = cond_trit(b.trits[i], subtract);   // -b for SUB

        trit_full_adder stage_i (
            .a         (a_t),
            .b         (b_t),
            .carry_in  (carry[i]),
            .sum       (sum.trits[i]),
            .carry_out (carry[i+1])
        );
    end

endmodule

`default_nettype wire

//--- adder/trit_full_adder.sv
`default_nettype none

// One balanced-ternary full adder stage
// a + b + carry_in == 3*carry_out + sum
module trit_full_adder (
    input  trit_pkg::trit_e a,
    input  trit_pkg::trit_e b,
    input  trit_pkg::trit_e carry_in,
    output trit_pkg::trit_e sum,
    output trit_pkg::trit_e carry_out
);

    import trit_pkg::*;

    // Carry and digit of a two-trit add
    typedef struct packed {
        trit_e carry;
        trit_e sum;
    } half_sum_s;

    function automatic half_sum_s half_add(input trit_e x, input trit_e y);
        half_sum_s r;
        r.carry = zero;
        r.sum   = zero;
        case ({x, y})
            {neg, neg}: begin
                r.carry = neg;          // -2 = -3 + 1
                r.sum   = pos;
            end
            {pos, pos}: begin
                r.carry = pos;          // +2 = +3 - 1
                r.sum   = neg;
            end
            {neg, zero}, {zero, neg}: r.sum = neg;
            {pos, zero}, {zero, pos}: r.sum = pos;
            default: r.sum = zero;      // Opposite trits cancel
        endcase
        return r;
    endfunction

    half_sum_s step1;
    half_sum_s step2;

    assign step1 = half_add(a, b);
    assign step2 = half_add(step1.sum, carry_in);   // Fold in the incoming carry

    assign sum = step2.sum;

    // Both partial carries can only be nonzero with opposite signs
    assign carry_out = (step1.carry == zero) ? step2.carry :
                       (step2.carry == zero) ? step1.carry : zero;

    // Callers clean up the unused code before it gets here
    always_comb begin
        assert (a !== 2'b11 && b !== 2'b11 && carry_in !== 2'b11)
            else $error("unused trit code at adder stage input");
    end

endmodule

`default_nettype wire

//--- source/trit_logic_unit.sv
`default_nettype none

`include "ternary_alu_defs.svh"

// Per-trit logic and whole-word equality
// Logic rules work on trit values ordered -1 < 0 < +1
module trit_logic_unit (
    input  trit_pkg::tword_u a,
    input  trit_pkg::tword_u b,
    output trit_pkg::tword_u not_word,
    output trit_pkg::tword_u and_word,
    output trit_pkg::tword_u or_word,
    output trit_pkg::tword_u xor_word,
    output trit_pkg::tword_u eq_word
);

    import trit_pkg::*;

    // Trit code to small signed value
    function automatic logic signed [1:0] rank(input trit_e t);
        case (t)
            pos:     return 2'sd1;
            neg:     return -2'sd1;
            default: return 2'sd0;   // Zero and the unused code
        endcase
    endfunction

    // Small signed value back to a trit code
    function automatic trit_e to_trit(input logic signed [1:0] r);
        if (r > 0) begin
            return pos;
        end
        if (r < 0) begin
            return neg;
        end
        return zero;
    endfunction

    for (genvar i = 0; i < `WORD_TRITS; i++) begin : g_trit
        logic signed [1:0] ra;
        logic signed [1:0] rb;

        assign ra = rank(a.trits[i]);
        assign rb = rank(b.trits[i]);

        // NOT is plain negation
        assign not_word.trits[i] = to_trit(-ra);

        assign and_word.trits[i] = to_trit((ra < rb) ? ra : rb);  // Minimum
        assign or_word.trits[i]  = to_trit((ra > rb) ? ra : rb);  // Maximum

        // Sum of the two trits
        // Equal nonzero pairs both fold to -1
        assign xor_word.trits[i] = (ra == rb && ra != 2'sd0) ? neg : to_trit(ra + rb);
    end

    // +1 in trit 0 on an exact bit match
    assign eq_word.bits = (a.bits == b.bits) ? {{(`WORD_TRITS-1){zero}}, pos} : '0;

endmodule

`default_nettype wire

//--- source/op_decoder.sv
`default_nettype none

// Opcode decode
// Turns the 3-trit opcode into an operation and a subtract flag
module op_decoder (
    input  alu_pkg::opcode_t  opcode,
    output alu_pkg::alu_req_s req
);

    import alu_pkg::*;

    always_comb begin
        // Anything not listed falls back to passing input1
        req.op       = pass_a;
        req.subtract = 1'b0;

        case (opcode)
            op_not: begin
                req.op = logic_not;
            end
            op_and, op_andi: begin
                req.op = logic_and;     // Immediate form has no separate path
            end
            op_or: begin
                req.op = logic_or;
            end
            op_xor: begin
                req.op = logic_xor;
            end
            op_add, op_addi: begin
                req.op = arith_add;
            end
            op_sub: begin
                req.op       = arith_sub;
                req.subtract = 1'b1;    // Adder sees -b
            end
            op_comp: begin
                req.op = cmp_eq;
            end
            default: begin
                req.op = pass_a;        // Unknown code
            end
        endcase
    end

endmodule

`default_nettype wire

//--- common/alu_pkg.sv
`default_nettype none

`include "ternary_alu_defs.svh"

// Operation types of the ALU
package alu_pkg;

    import trit_pkg::*;

    // 3-trit opcode, most significant trit first
    typedef logic [`OPCODE_TRITS*`TRIT_BITS-1:0] opcode_t;

    // Code points run +1 to +9 in balanced ternary
    localparam opcode_t op_not  = {zero, zero, pos};   // +1
    localparam opcode_t op_and  = {zero, pos,  neg};   // +2
    localparam opcode_t op_andi = {zero, pos,  zero};  // +3, alias of AND
    localparam opcode_t op_or   = {zero, pos,  pos};   // +4
    localparam opcode_t op_xor  = {pos,  neg,  neg};   // +5
    localparam opcode_t op_add  = {pos,  neg,  zero};  // +6
    localparam opcode_t op_addi = {pos,  neg,  pos};   // +7, alias of ADD
    localparam opcode_t op_sub  = {pos,  zero, neg};   // +8
    localparam opcode_t op_comp = {pos,  zero, zero};  // +9

    // Decoded operation
    typedef enum logic [2:0] {
        logic_not, logic_and, logic_or, logic_xor,
        arith_add, arith_sub, cmp_eq, pass_a
    } alu_op_e;

    // Decoded request sent out by the decoder
    typedef struct packed {
        alu_op_e op;         // Result select
        logic    subtract;   // Negate second adder operand
    } alu_req_s;

endpackage

`default_nettype wire

//--- common/trit_pkg.sv
`default_nettype none

`include "ternary_alu_defs.svh"

// Number-system types shared by the datapath
package trit_pkg;

    // One balanced-ternary digit
    // 2'b11 is never produced by the datapath
    // Units that read raw words treat it as zero
    typedef enum logic [`TRIT_BITS-1:0] {
        zero = 2'b00,   // 0
        pos  = 2'b01,   // +1
        neg  = 2'b10    // -1
    } trit_e;

    // One 9-trit data word, 18 bits
    // The trit view is used for per-digit work
    // The flat view serves whole-word compare and clearing
    typedef union packed {
        trit_e [`WORD_TRITS-1:0]           trits;   // Trit 0 is least significant
        logic  [`WORD_TRITS*`TRIT_BITS-1:0] bits;   // Raw bit pattern
    } tword_u;

    // Value range of a word is +-9841
    // Largest value is all trits at +1
    // Smallest value is all trits at -1

endpackage

`default_nettype wire

//--- common/ternary_alu_defs.svh
`ifndef TERNARY_ALU_DEFS_SVH
`define TERNARY_ALU_DEFS_SVH

// Trit coding per 2-bit slot
//   2'b10  -1
//   2'b00   0
//   2'b01  +1
//   2'b11   unused, read as 0

// Bits per trit
`define TRIT_BITS 2

// Trits per data word
`define WORD_TRITS 9

// Trits per opcode
`define OPCODE_TRITS 3

`endif
